// File: hdl/tl_memory_consts.svh
/*
 * Bus, memory and opcode constants for the TileLink-UL memory
 */

`ifndef TL_MEMORY_CONSTS_SVH
`define TL_MEMORY_CONSTS_SVH

// Bus geometry
`define TL_XLEN        32   // Data bits per beat
`define TL_LANES       4    // Byte lanes per beat

// Backing store
`define TL_MEM_BYTES   1024
`define TL_MEM_WORDS   256  // TL_MEM_BYTES / TL_LANES

// Source ID width on both channels
`define TL_SID_WIDTH   2

// A channel opcodes
`define TL_OP_GET             3'd4
`define TL_OP_PUT_FULL        3'd0

// D channel opcodes
`define TL_D_ACCESS_ACK       3'd0  // Write ack, no data
`define TL_D_ACCESS_ACK_DATA  3'd1  // Read ack with data

`endif

// File: hdl/tl_memory_pkg.sv
/*
 * Width typedefs, A/D channel beat structs and the stage 1 to stage 2 access record
 */

package tl_memory_pkg;

    ////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] tl_addr_t;       // Byte address
    typedef logic [31:0] tl_data_t;       // One bus beat
    typedef logic [3:0]  tl_mask_t;       // One bit per byte lane
    typedef logic [1:0]  tl_source_t;
    typedef logic [2:0]  tl_size_t;       // Log2 of bytes
    typedef logic [2:0]  tl_opcode_t;
    typedef logic [7:0]  tl_word_index_t; // RAM word address
    typedef logic [1:0]  tl_lane_t;       // Byte offset in word

    ////////////////////////////////////////////////////////////
    // Channel beats
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        tl_opcode_t opcode;
        logic [2:0] param;     // Unused by this slave
        tl_size_t   size;
        tl_source_t source;
        tl_addr_t   address;
        tl_mask_t   mask;
        tl_data_t   data;
    } tl_a_beat_t;

    typedef struct packed {
        tl_opcode_t opcode;
        logic [1:0] param;     // Always zero
        tl_size_t   size;
        tl_source_t source;
        tl_data_t   data;
        logic       corrupt;
        logic       denied;
    } tl_d_beat_t;

    // What stage 2 needs to finish a request
    typedef struct packed {
        logic       read;      // Get, else AccessAck
        tl_size_t   size;
        tl_source_t source;
        tl_lane_t   lane;      // Read extraction offset
        logic       denied;
    } tl_access_t;

endpackage

// File: hdl/tl_request_check.sv
/*
 * Stage 1: A channel acceptance, request checks, RAM port drive, access record
 */

`timescale 1ns/1ps

`include "tl_memory_consts.svh"

module tl_request_check (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           tl_a_valid,
    input  tl_memory_pkg::tl_a_beat_t      tl_a,
    input  logic                           stall,
    output logic                           tl_a_ready,
    output tl_memory_pkg::tl_mask_t        ram_we,
    output logic                           ram_re,
    output tl_memory_pkg::tl_word_index_t  ram_index,
    output tl_memory_pkg::tl_data_t        ram_wdata,
    output logic                           access_valid,
    output tl_memory_pkg::tl_access_t      access
);

    logic                     ready_en;   // Low until first edge out of reset
    logic                     accept;     // A handshake this cycle
    logic                     is_get;
    logic                     is_put;
    logic                     size_bad;
    logic                     range_bad;
    logic                     mask_bad;
    logic                     denied;
    tl_memory_pkg::tl_lane_t  lane;
    tl_memory_pkg::tl_mask_t  size_mask;  // Lanes covered at offset 0
    tl_memory_pkg::tl_addr_t  last_ok;    // Highest legal start address
    logic [7:0]               lane_span;  // Expected mask, may run past lane 3

    ////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////

    // Ready drops in the same cycle the D side stalls
    assign tl_a_ready = ready_en && !stall;
    assign accept     = tl_a_valid && tl_a_ready;

    ////////////////////////////////////////////////////////////
    // Request checks
    ////////////////////////////////////////////////////////////

    assign is_get = (tl_a.opcode == `TL_OP_GET);
    assign is_put = (tl_a.opcode == `TL_OP_PUT_FULL);
    assign lane   = tl_a.address[1:0];

    always_comb begin
        case (tl_a.size[1:0])
            2'd0:    size_mask = 4'b0001;  // Byte
            2'd1:    size_mask = 4'b0011;  // Halfword
            default: size_mask = 4'b1111;  // Word, oversize is denied anyway
        endcase
    end

    // 1024 minus access width
    assign last_ok   = `TL_MEM_BYTES - (32'd1 << tl_a.size[1:0]);
    assign size_bad  = (tl_a.size > 3'd2);
    assign range_bad = (tl_a.address > last_ok);

    // Put mask must be exactly the lanes at the offset, nothing spilling over
    assign lane_span = {4'b0000, size_mask} << lane;
    assign mask_bad  = is_put && (lane_span != {4'b0000, tl_a.mask});

    assign denied = size_bad || range_bad || mask_bad || !(is_get || is_put);

    ////////////////////////////////////////////////////////////
    // RAM port, same edge as acceptance
    ////////////////////////////////////////////////////////////

    assign ram_index = tl_a.address[$clog2(`TL_MEM_BYTES)-1:2];
    assign ram_wdata = tl_a.data << {lane, 3'b000};  // Low bytes moved up to the offset
    assign ram_we    = (accept && is_put && !denied) ? tl_a.mask : 4'b0000;
    assign ram_re    = accept && is_get && !denied;

    ////////////////////////////////////////////////////////////
    // Access record
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready_en     <= 1'b0;
            access_valid <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (!stall) begin
                access_valid <= accept;  // Bubble when nothing came in
            end
        end
    end

    // Payload only moves on a handshake, which never happens while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            access <= '{
                read:   is_get,
                size:   tl_a.size,
                source: tl_a.source,
                lane:   lane,
                denied: denied
            };
        end
    end

endmodule

// File: hdl/tl_byte_ram.sv
/*
 * Word-organized byte memory, per-lane write enables, registered read port
 */

`timescale 1ns/1ps

`include "tl_memory_consts.svh"

module tl_byte_ram #(
    parameter int DEPTH = `TL_MEM_WORDS  // Words
) (
    input  logic                           clk,
    input  tl_memory_pkg::tl_mask_t        ram_we,
    input  logic                           ram_re,
    input  tl_memory_pkg::tl_word_index_t  ram_index,
    input  tl_memory_pkg::tl_data_t        ram_wdata,
    output tl_memory_pkg::tl_data_t        ram_rdata
);

    // One byte column per lane
    for (genvar l = 0; l < `TL_LANES; l++) begin : g_lane
        logic [7:0] mem [DEPTH];

        // Lane write
        always_ff @(posedge clk) begin
            if (ram_we[l]) begin
                mem[ram_index] <= ram_wdata[8*l +: 8];
            end
        end

        // Read data holds between strobes
        always_ff @(posedge clk) begin
            if (ram_re) begin
                ram_rdata[8*l +: 8] <= mem[ram_index];
            end
        end
    end

endmodule

// File: hdl/tl_response_build.sv
/*
 * Stage 2: read lane extraction, D beat formation, hold under back-pressure
 */

`timescale 1ns/1ps

`include "tl_memory_consts.svh"

module tl_response_build (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       access_valid,
    input  tl_memory_pkg::tl_access_t  access,
    input  tl_memory_pkg::tl_data_t    ram_rdata,
    input  logic                       tl_d_ready,
    output logic                       stall,
    output logic                       tl_d_valid,
    output tl_memory_pkg::tl_d_beat_t  tl_d
);

    tl_memory_pkg::tl_data_t    lane_data;  // Word shifted down to the offset
    tl_memory_pkg::tl_data_t    read_data;  // Zero-extended to access width
    tl_memory_pkg::tl_d_beat_t  d_next;

    ////////////////////////////////////////////////////////////
    // Read extraction
    ////////////////////////////////////////////////////////////

    assign lane_data = ram_rdata >> {access.lane, 3'b000};

    always_comb begin
        case (access.size)
            3'd0:    read_data = {{(`TL_XLEN-8){1'b0}}, lane_data[7:0]};
            3'd1:    read_data = {{(`TL_XLEN-16){1'b0}}, lane_data[15:0]};
            default: read_data = lane_data;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // D beat
    ////////////////////////////////////////////////////////////

    always_comb begin
        d_next.opcode  = access.read ? `TL_D_ACCESS_ACK_DATA : `TL_D_ACCESS_ACK;
        d_next.param   = 2'b00;
        d_next.size    = access.size;
        d_next.source  = access.source;
        d_next.denied  = access.denied;
        d_next.corrupt = access.denied && access.read;  // Denied data is never valid
        // No data on writes or refusals
        if (access.read && !access.denied) begin
            d_next.data = read_data;
        end else begin
            d_next.data = '0;
        end
    end

    // Beat waiting on the master
    assign stall = tl_d_valid && !tl_d_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tl_d_valid <= 1'b0;
        end else if (!stall) begin
            tl_d_valid <= access_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            tl_d <= d_next;  // Frozen while stalled
        end
    end

endmodule

// File: hdl/tl_memory_top.sv
/*
 * TileLink-UL memory slave top: request check, byte RAM, response build
 */

`timescale 1ns/1ps

module tl_memory_top (
    input  logic                       clk,
    input  logic                       reset,

    // A channel
    input  logic                       tl_a_valid,
    output logic                       tl_a_ready,
    input  tl_memory_pkg::tl_a_beat_t  tl_a,

    // D channel
    output logic                       tl_d_valid,
    input  logic                       tl_d_ready,
    output tl_memory_pkg::tl_d_beat_t  tl_d
);

    ////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////

    logic                           stall;         // Stage 2 holding a beat
    tl_memory_pkg::tl_mask_t        ram_we;
    logic                           ram_re;
    tl_memory_pkg::tl_word_index_t  ram_index;
    tl_memory_pkg::tl_data_t        ram_wdata;
    tl_memory_pkg::tl_data_t        ram_rdata;     // Aligned with access record
    logic                           access_valid;
    tl_memory_pkg::tl_access_t      access;

    // Stage 1
    tl_request_check u_request_check (
        .clk          (clk),
        .reset        (reset),
        .tl_a_valid   (tl_a_valid),
        .tl_a         (tl_a),
        .stall        (stall),
        .tl_a_ready   (tl_a_ready),
        .ram_we       (ram_we),
        .ram_re       (ram_re),
        .ram_index    (ram_index),
        .ram_wdata    (ram_wdata),
        .access_valid (access_valid),
        .access       (access)
    );

    tl_byte_ram u_byte_ram (
        .clk       (clk),
        .ram_we    (ram_we),
        .ram_re    (ram_re),
        .ram_index (ram_index),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    // Stage 2
    tl_response_build u_response_build (
        .clk          (clk),
        .reset        (reset),
        .access_valid (access_valid),
        .access       (access),
        .ram_rdata    (ram_rdata),
        .tl_d_ready   (tl_d_ready),
        .stall        (stall),
        .tl_d_valid   (tl_d_valid),
        .tl_d         (tl_d)
    );

endmodule

// File: test/tl_memory_properties.sv
/*
 * Protocol assertions for tl_memory_top, attached with bind
 */

`timescale 1ns/1ps

module tl_memory_properties (
    input logic                       clk,
    input logic                       reset,
    input logic                       tl_a_valid,
    input logic                       tl_a_ready,
    input logic                       tl_d_valid,
    input logic                       tl_d_ready,
    input tl_memory_pkg::tl_d_beat_t  tl_d
);

    ////////////////////////////////////////////////////////////
    // D channel
    ////////////////////////////////////////////////////////////

    // Beat frozen while the master holds off
    d_stable_when_stalled: assert property (@(posedge clk) disable iff (reset)
        (tl_d_valid && !tl_d_ready) |=> (tl_d_valid && $stable(tl_d)))
        else $error("D beat changed or dropped while stalled");

    ////////////////////////////////////////////////////////////
    // Reset
    ////////////////////////////////////////////////////////////

    quiet_in_reset: assert property (@(posedge clk)
        reset |-> (!tl_a_ready && !tl_d_valid))
        else $error("Handshake outputs active during reset");

    ////////////////////////////////////////////////////////////
    // Latency
    ////////////////////////////////////////////////////////////

    // Two edges from A handshake to D valid while the D side never stalls
    two_cycle_latency: assert property (@(posedge clk) disable iff (reset)
        (tl_a_valid && tl_a_ready && tl_d_ready) ##1 tl_d_ready |=> tl_d_valid)
        else $error("Response not valid two cycles after request");

endmodule

bind tl_memory_top tl_memory_properties u_properties (.*);

// File: test/tl_memory_tb.sv
/*
 * Testbench for tl_memory_top: clock, reset, directed and random stimulus,
 * byte-array reference model, expected D beat queue and response assertion
 */

`timescale 1ns/1ps

`include "tl_memory_consts.svh"

module tl_memory_tb;

    // Fill, directed and random transactions, 4 cycles each, plus reset slack
    localparam int CYCLE_LIMIT = (`TL_MEM_WORDS + 20 + 300) * 4 + 20;

    logic                       clk;
    logic                       reset;
    logic                       tl_a_valid;
    logic                       tl_a_ready;
    tl_memory_pkg::tl_a_beat_t  tl_a;
    logic                       tl_d_valid;
    logic                       tl_d_ready;
    tl_memory_pkg::tl_d_beat_t  tl_d;

    logic [7:0]                 model_mem [`TL_MEM_BYTES];  // Reference bytes
    tl_memory_pkg::tl_d_beat_t  exp_q [$];
    tl_memory_pkg::tl_d_beat_t  exp_head;                   // Stable copy of queue front
    logic                       exp_pending;
    logic [31:0]                lcg_state;
    logic                       random_ready;               // D back-pressure on/off
    int                         issued;
    int                         checked;
    int                         cycles;

    tl_memory_top u_tl_memory_top (
        .clk        (clk),
        .reset      (reset),
        .tl_a_valid (tl_a_valid),
        .tl_a_ready (tl_a_ready),
        .tl_a       (tl_a),
        .tl_d_valid (tl_d_valid),
        .tl_d_ready (tl_d_ready),
        .tl_d       (tl_d)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic set_d_ready();
        logic [31:0] r;
        r = lcg_next();
        tl_d_ready = random_ready ? (r[17:16] != 2'b00) : 1'b1;  // ~25% gaps
    endtask

    // Apply one accepted A beat to the model, queue its D beat
    task automatic model_access(input tl_memory_pkg::tl_a_beat_t a);
        tl_memory_pkg::tl_d_beat_t d;
        longint unsigned width;
        longint unsigned span;
        logic            is_get;
        logic            is_put;
        logic            denied;
        width  = (a.size > 3'd2) ? 1 : (64'd1 << a.size);
        span   = ((64'd1 << width) - 1) << a.address[1:0];
        is_get = (a.opcode == `TL_OP_GET);
        is_put = (a.opcode == `TL_OP_PUT_FULL);
        denied = (a.size > 3'd2) || !(is_get || is_put);
        denied = denied || (longint'(a.address) > `TL_MEM_BYTES - width);
        denied = denied || (is_put && span != longint'(a.mask));
        d         = '0;
        d.opcode  = is_get ? `TL_D_ACCESS_ACK_DATA : `TL_D_ACCESS_ACK;
        d.size    = a.size;
        d.source  = a.source;
        d.denied  = denied;
        d.corrupt = denied && is_get;
        if (!denied) begin
            for (int i = 0; i < width; i++) begin
                if (is_put) begin
                    model_mem[a.address + i] = a.data[8*i +: 8];
                end else begin
                    d.data[8*i +: 8] = model_mem[a.address + i];  // Zero-extended
                end
            end
        end
        exp_q.push_back(d);
        issued++;
    endtask

    // Holds the beat until the DUT takes it
    task automatic send_request(input logic [2:0] op, input logic [2:0] size,
                                input logic [1:0] source, input logic [31:0] address,
                                input logic [3:0] mask, input logic [31:0] data);
        @(negedge clk);
        tl_a_valid = 1'b1;
        tl_a = '{opcode: op, param: 3'd0, size: size, source: source,
                 address: address, mask: mask, data: data};
        set_d_ready();
        #1;
        while (!tl_a_ready) begin
            @(negedge clk);
            set_d_ready();
            #1;
        end
        model_access(tl_a);  // Taken at the coming edge
    endtask

    task automatic drain_responses();
        @(negedge clk);
        tl_a_valid = 1'b0;
        tl_d_ready = 1'b1;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // Every byte written first so no read sees uninitialized RAM
    task automatic fill_memory();
        logic [31:0] a;
        for (int w = 0; w < `TL_MEM_WORDS; w++) begin
            a = w * 4;
            send_request(`TL_OP_PUT_FULL, 3'd2, w[1:0], a, 4'hf,
                         (a * 32'h01000193) ^ 32'h5a5a_c3c3);
        end
    endtask

    task automatic random_request();
        logic [31:0] r;
        logic [2:0]  op;
        logic [2:0]  size;
        logic [31:0] address;
        logic [3:0]  mask;
        r    = lcg_next();
        size = (r[1:0] == 2'd3) ? (r[2] ? 3'd3 : 3'd2) : {1'b0, r[1:0]};
        op   = (r[7:4] == 4'd0) ? 3'd2 : (r[8] ? `TL_OP_GET : `TL_OP_PUT_FULL);
        address = lcg_next() % `TL_MEM_BYTES;
        if (size <= 3'd2) begin
            address = address & ~((32'd1 << size) - 1);  // Natural alignment
            mask    = ((4'd1 << (1 << size)) - 4'd1) << address[1:0];
        end else begin
            mask = 4'hf;
        end
        if (r[12:9] == 4'd0) begin
            address = `TL_MEM_BYTES - r[14:13];  // Near or past the top
        end
        if (r[19:16] == 4'd0) begin
            mask = r[23:20];  // Often wrong
        end
        send_request(op, size, r[25:24], address, mask, lcg_next());
    endtask

    ////////////////////////////////////////////////////////////
    // Response checking
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input tl_memory_pkg::tl_d_beat_t got);
        if (!exp_pending) begin
            $display("D beat arrived with no request outstanding");
        end else begin
            if (got.opcode != exp_head.opcode)
                $display("FAILED tl_d.opcode got %h expected %h", got.opcode, exp_head.opcode);
            if (got.size != exp_head.size)
                $display("FAILED tl_d.size got %h expected %h", got.size, exp_head.size);
            if (got.source != exp_head.source)
                $display("FAILED tl_d.source got %h expected %h", got.source, exp_head.source);
            if (got.data !== exp_head.data)
                $display("FAILED tl_d.data got %h expected %h", got.data, exp_head.data);
            if (got.denied != exp_head.denied)
                $display("FAILED tl_d.denied got %h expected %h", got.denied, exp_head.denied);
            if (got.corrupt != exp_head.corrupt)
                $display("FAILED tl_d.corrupt got %h expected %h",
                         got.corrupt, exp_head.corrupt);
            if (got.param != exp_head.param)
                $display("FAILED tl_d.param got %h expected %h", got.param, exp_head.param);
        end
        $display("Errors found");
        $fatal(1);
    endtask

    response_matches: assert property (@(posedge clk) disable iff (reset)
        (tl_d_valid && tl_d_ready) |-> (exp_pending && tl_d === exp_head))
        else report_mismatch($sampled(tl_d));

    always @(posedge clk) begin
        if (!reset && tl_d_valid && tl_d_ready && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            checked++;
        end
    end

    // Front of queue refreshed away from the sampling edge
    always @(negedge clk) begin
        exp_pending = (exp_q.size() != 0);
        exp_head    = exp_pending ? exp_q[0] : '0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        reset        = 1'b1;
        tl_a_valid   = 1'b0;
        tl_a         = '0;
        tl_d_ready   = 1'b1;
        random_ready = 1'b0;
        lcg_state    = 32'heaf;
        issued       = 0;
        checked      = 0;
        cycles       = 0;
        exp_pending  = 1'b0;
        exp_head     = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fill_memory();

        // Word write then read back to back
        send_request(`TL_OP_PUT_FULL, 3'd2, 2'd1, 32'h40, 4'hf, 32'hdead_beef);
        send_request(`TL_OP_GET,      3'd2, 2'd2, 32'h40, 4'hf, 32'h0);
        // Narrow writes touch only their lanes
        send_request(`TL_OP_PUT_FULL, 3'd0, 2'd3, 32'h41, 4'b0010, 32'h1234_56a5);
        send_request(`TL_OP_PUT_FULL, 3'd1, 2'd0, 32'h46, 4'b1100, 32'hffff_1234);
        for (int i = 0; i < 4; i++) begin
            send_request(`TL_OP_GET, 3'd0, i[1:0], 32'h40 + i, 4'b0001 << i, 32'h0);
        end
        send_request(`TL_OP_GET, 3'd1, 2'd1, 32'h44, 4'b0011, 32'h0);
        send_request(`TL_OP_GET, 3'd1, 2'd2, 32'h46, 4'b1100, 32'h0);
        send_request(`TL_OP_GET, 3'd1, 2'd3, 32'h41, 4'b0110, 32'h0);
        send_request(`TL_OP_GET, 3'd2, 2'd3, 32'h44, 4'hf, 32'h0);
        // Out of range
        send_request(`TL_OP_GET,      3'd2, 2'd0, 32'h3fd, 4'hf, 32'h0);
        send_request(`TL_OP_PUT_FULL, 3'd2, 2'd1, 32'h400, 4'hf, 32'h0bad_beef);  // Word 0 alias
        send_request(`TL_OP_GET,      3'd2, 2'd2, 32'h3fc, 4'hf, 32'h0);
        send_request(`TL_OP_GET,      3'd2, 2'd3, 32'h0, 4'hf, 32'h0);
        // Bad mask, oversize, unknown opcode
        send_request(`TL_OP_PUT_FULL, 3'd2, 2'd3, 32'h50, 4'b0001, 32'h1111_1111);
        send_request(`TL_OP_PUT_FULL, 3'd3, 2'd0, 32'h50, 4'hf, 32'h2222_2222);
        send_request(3'd2,            3'd2, 2'd1, 32'h50, 4'hf, 32'h3333_3333);
        send_request(`TL_OP_GET,      3'd2, 2'd2, 32'h50, 4'hf, 32'h0);
        drain_responses();

        random_ready = 1'b1;  // D gaps from here on
        for (int n = 0; n < 300; n++) begin
            random_request();
        end
        drain_responses();

        if (checked != issued || exp_q.size() != 0) begin
            $display("Response count wrong: %0d requests, %0d responses", issued, checked);
            $display("Errors found");
            $fatal(1);
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: tl_memory_top.f
+incdir+hdl
hdl/tl_memory_pkg.sv
hdl/tl_request_check.sv
hdl/tl_byte_ram.sv
hdl/tl_response_build.sv
hdl/tl_memory_top.sv
test/tl_memory_properties.sv
test/tl_memory_tb.sv

// File: Makefile
# Verilator build and run for the TileLink-UL memory testbench

VERILATOR  ?= verilator
TOP        := tl_memory_tb
FILELIST   := tl_memory_top.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
